//--- Bender.yml
package:
  name: csr_user_unit

dependencies: {}

sources:
  # Package first, then the blocks, then the top level
  - rtl/csrPkg.sv
  - rtl/csrWriteValue.sv
  - rtl/csrUserStatus.sv
  - rtl/csrUserTrap.sv
  - rtl/csrUserUnit.sv

  # Testbench, only for simulation
  - target: test
    files:
      - verification/csrUserTb.sv

//--- flist.f
rtl/csrPkg.sv
rtl/csrWriteValue.sv
rtl/csrUserStatus.sv
rtl/csrUserTrap.sv
rtl/csrUserUnit.sv
verification/csrUserTb.sv

//--- rtl/csrPkg.sv
`default_nettype none

package csrPkg;

  ////////////////////
  // Widths and types
  ////////////////////

  // Data width of every user CSR
  localparam int XLEN = 32;

  // One CSR word, the type of every register value and operand
  typedef logic [XLEN-1:0] wordT;

  // The 12-bit CSR address field of the instruction
  typedef logic [11:0] csrAddrT;

  // Interrupt enable and pending fields as kept in uie and uip
  typedef logic [11:0] intBitsT;

  // Kind of CSR instruction, coded like the low two bits of funct3
  typedef enum logic [1:0] {
    csrRw = 2'b01,
    csrRs = 2'b10,
    csrRc = 2'b11
  } csrOpT;

  ////////////////////
  // User CSR map
  ////////////////////

  localparam csrAddrT USTATUS_ADR  = 12'h000;
  localparam csrAddrT UIE_ADR      = 12'h004;
  localparam csrAddrT UTVEC_ADR    = 12'h005;
  localparam csrAddrT USCRATCH_ADR = 12'h040;
  localparam csrAddrT UEPC_ADR     = 12'h041;
  localparam csrAddrT UCAUSE_ADR   = 12'h042;
  localparam csrAddrT UTVAL_ADR    = 12'h043;
  localparam csrAddrT UIP_ADR      = 12'h044;

  // Bit positions inside ustatus
  localparam int UIE_BIT  = 0;
  localparam int UPIE_BIT = 4;

  // Software, timer and external interrupt bits, shared by uie and uip
  localparam int USI_BIT = 0;
  localparam int UTI_BIT = 4;
  localparam int UEI_BIT = 8;

endpackage

`default_nettype wire

//--- rtl/csrUserStatus.sv
`default_nettype none

module csrUserStatus (
  input  logic             clk,
  input  logic             rst,
  input  logic             writeUstatus,
  input  logic             writeUie,
  input  logic             writeUip,
  input  csrPkg::wordT     writeVal,
  input  logic             uTrap,
  input  logic             uRet,
  input  logic             irqTimer,
  input  logic             irqExt,
  output csrPkg::wordT     ustatusVal,
  output csrPkg::intBitsT  uieVal,
  output csrPkg::intBitsT  uipVal,
  output logic             uIrqPending
);

  import csrPkg::*;

  // The interrupt bits that exist in uie, all others read zero
  localparam intBitsT intMask = intBitsT'((1 << USI_BIT) | (1 << UTI_BIT) | (1 << UEI_BIT));

  // Global enable and its copy saved on trap entry
  logic uieBit;
  logic upieBit;

  // Stored enable bits and the software pending bit
  intBitsT uieReg;
  logic    usipBit;

  ////////////////////
  // ustatus
  ////////////////////

  // Trap entry and return take priority over a ustatus write
  // The two pulses are exclusive, so their order here does not matter
  always_ff @(posedge clk) begin
    if (rst) begin
      uieBit  <= 1'b0;
      upieBit <= 1'b0;
    end else if (uTrap) begin
      // Save the enable and mask interrupts inside the handler
      upieBit <= uieBit;
      uieBit  <= 1'b0;
    end else if (uRet) begin
      // Restore the enable that was live before the trap
      uieBit  <= upieBit;
      upieBit <= 1'b1;
    end else if (writeUstatus) begin
      uieBit  <= writeVal[UIE_BIT];
      upieBit <= writeVal[UPIE_BIT];
    end
  end

  // Only the two enable bits are implemented
  always_comb begin
    ustatusVal = '0;
    ustatusVal[UIE_BIT]  = uieBit;
    ustatusVal[UPIE_BIT] = upieBit;
  end

  ////////////////////
  // uie and uip
  ////////////////////

  // uie keeps the software, timer and external enables
  // uip keeps only the software bit, set and cleared by CSR writes
  always_ff @(posedge clk) begin
    if (rst) begin
      uieReg  <= '0;
      usipBit <= 1'b0;
    end else begin
      if (writeUie) begin
        uieReg <= intBitsT'(writeVal) & intMask;
      end
      if (writeUip) begin
        usipBit <= writeVal[USI_BIT];
      end
    end
  end

  assign uieVal = uieReg;

  // Timer and external pending bits mirror the interrupt levels directly
  always_comb begin
    uipVal = '0;
    uipVal[USI_BIT] = usipBit;
    uipVal[UTI_BIT] = irqTimer;
    uipVal[UEI_BIT] = irqExt;
  end

  // An interrupt is taken when it is pending, enabled and globally allowed
  assign uIrqPending = uieBit & (|(uieReg & uipVal));

  // The core never enters and leaves a user trap in the same cycle
  trapRetExclusive: assert property (@(posedge clk) disable iff (rst) !(uTrap && uRet));

endmodule

`default_nettype wire

//--- rtl/csrUserTrap.sv
`default_nettype none

module csrUserTrap #(
  parameter csrPkg::wordT resetVector = '0
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             instrValid,
  input  logic             csrWrite,
  input  csrPkg::csrAddrT  csrAddr,
  input  csrPkg::wordT     writeVal,
  input  csrPkg::wordT     nextEpc,
  input  csrPkg::wordT     nextCause,
  input  csrPkg::wordT     nextTval,
  input  logic             uTrap,
  input  csrPkg::wordT     ustatusVal,
  input  csrPkg::intBitsT  uieVal,
  input  csrPkg::intBitsT  uipVal,
  output logic             writeUstatus,
  output logic             writeUie,
  output logic             writeUip,
  output csrPkg::wordT     readVal,
  output logic             illegalCsr,
  output csrPkg::wordT     uepcOut,
  output csrPkg::wordT     utvecOut
);

  import csrPkg::*;

  // A CSR instruction that is allowed to change state this cycle
  logic csrWriteOk;

  // Strobes for the registers held in this block
  logic writeUtvec;
  logic writeUscratch;
  logic writeUepc;
  logic writeUcause;
  logic writeUtval;

  wordT uscratchReg;
  wordT ucauseReg;
  wordT utvalReg;

  ////////////////////
  // Write decode
  ////////////////////

  assign csrWriteOk = instrValid & csrWrite;

  // An address outside the map matches no strobe, so nothing changes
  assign writeUstatus  = csrWriteOk & (csrAddr == USTATUS_ADR);
  assign writeUie      = csrWriteOk & (csrAddr == UIE_ADR);
  assign writeUtvec    = csrWriteOk & (csrAddr == UTVEC_ADR);
  assign writeUscratch = csrWriteOk & (csrAddr == USCRATCH_ADR);
  assign writeUepc     = csrWriteOk & (csrAddr == UEPC_ADR);
  assign writeUcause   = csrWriteOk & (csrAddr == UCAUSE_ADR);
  assign writeUtval    = csrWriteOk & (csrAddr == UTVAL_ADR);
  assign writeUip      = csrWriteOk & (csrAddr == UIP_ADR);

  ////////////////////
  // Registers
  ////////////////////

  // utvec resets to the trap vector given by the top level
  // Bit 1 is reserved in the mode field and always reads zero
  always_ff @(posedge clk) begin
    if (rst) begin
      utvecOut <= resetVector;
    end else if (writeUtvec) begin
      utvecOut <= {writeVal[XLEN-1:2], 1'b0, writeVal[0]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      uscratchReg <= '0;
    end else if (writeUscratch) begin
      uscratchReg <= writeVal;
    end
  end

  // Trap capture wins over a CSR write in the same cycle
  // uepc holds an instruction address, so bit 0 is never set
  always_ff @(posedge clk) begin
    if (rst) begin
      uepcOut   <= '0;
      ucauseReg <= '0;
      utvalReg  <= '0;
    end else if (uTrap) begin
      uepcOut   <= {nextEpc[XLEN-1:1], 1'b0};
      ucauseReg <= nextCause;
      utvalReg  <= nextTval;
    end else begin
      if (writeUepc) begin
        uepcOut <= {writeVal[XLEN-1:1], 1'b0};
      end
      if (writeUcause) begin
        ucauseReg <= writeVal;
      end
      if (writeUtval) begin
        utvalReg <= writeVal;
      end
    end
  end

  ////////////////////
  // Read mux
  ////////////////////

  // Reads are combinational and also feed the set and clear logic
  always_comb begin
    illegalCsr = 1'b0;
    case (csrAddr)
      USTATUS_ADR:  readVal = ustatusVal;
      UIE_ADR:      readVal = wordT'(uieVal);
      UTVEC_ADR:    readVal = utvecOut;
      USCRATCH_ADR: readVal = uscratchReg;
      UEPC_ADR:     readVal = uepcOut;
      UCAUSE_ADR:   readVal = ucauseReg;
      UTVAL_ADR:    readVal = utvalReg;
      UIP_ADR:      readVal = wordT'(uipVal);
      default: begin
        readVal    = '0;
        illegalCsr = 1'b1;
      end
    endcase
  end

  // The status block must never see a strobe for an unmapped address
  noWriteOnIllegal: assert property (@(posedge clk) disable iff (rst)
    illegalCsr |-> !(writeUstatus | writeUie | writeUip | writeUtvec |
                     writeUscratch | writeUepc | writeUcause | writeUtval));

endmodule

`default_nettype wire

//--- rtl/csrUserUnit.sv
`default_nettype none

module csrUserUnit #(
  parameter csrPkg::wordT resetVector = 32'h0000_1000
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             instrValid,
  input  logic             csrWrite,
  input  csrPkg::csrOpT    csrOp,
  input  csrPkg::csrAddrT  csrAddr,
  input  csrPkg::wordT     csrSrc,
  input  logic             uTrap,
  input  logic             uRet,
  input  csrPkg::wordT     nextEpc,
  input  csrPkg::wordT     nextCause,
  input  csrPkg::wordT     nextTval,
  input  logic             irqTimer,
  input  logic             irqExt,
  output csrPkg::wordT     csrReadVal,
  output logic             illegalCsr,
  output csrPkg::wordT     uepcOut,
  output csrPkg::wordT     utvecOut,
  output logic             uIrqPending
);

  import csrPkg::*;

  ////////////////////
  // Internal wires
  ////////////////////

  // Value formed from the operation, stored by whichever register is strobed
  wordT writeVal;

  // Strobes for the registers kept in the status block
  logic writeUstatus;
  logic writeUie;
  logic writeUip;

  // Status block contents, needed only by the read mux
  wordT    ustatusVal;
  intBitsT uieVal;
  intBitsT uipVal;

  // The read value leaves the unit and loops back for set and clear
  csrWriteValue writeValue (
    .csrOp    (csrOp),
    .csrSrc   (csrSrc),
    .readVal  (csrReadVal),
    .writeVal (writeVal)
  );

  csrUserStatus userStatus (
    .clk          (clk),
    .rst          (rst),
    .writeUstatus (writeUstatus),
    .writeUie     (writeUie),
    .writeUip     (writeUip),
    .writeVal     (writeVal),
    .uTrap        (uTrap),
    .uRet         (uRet),
    .irqTimer     (irqTimer),
    .irqExt       (irqExt),
    .ustatusVal   (ustatusVal),
    .uieVal       (uieVal),
    .uipVal       (uipVal),
    .uIrqPending  (uIrqPending)
  );

  // Address decode, trap registers and the read mux
  csrUserTrap #(
    .resetVector (resetVector)
  ) userTrap (
    .clk          (clk),
    .rst          (rst),
    .instrValid   (instrValid),
    .csrWrite     (csrWrite),
    .csrAddr      (csrAddr),
    .writeVal     (writeVal),
    .nextEpc      (nextEpc),
    .nextCause    (nextCause),
    .nextTval     (nextTval),
    .uTrap        (uTrap),
    .ustatusVal   (ustatusVal),
    .uieVal       (uieVal),
    .uipVal       (uipVal),
    .writeUstatus (writeUstatus),
    .writeUie     (writeUie),
    .writeUip     (writeUip),
    .readVal      (csrReadVal),
    .illegalCsr   (illegalCsr),
    .uepcOut      (uepcOut),
    .utvecOut     (utvecOut)
  );

endmodule

`default_nettype wire

//--- rtl/csrWriteValue.sv
`default_nettype none

module csrWriteValue (
  input  csrPkg::csrOpT csrOp,
  input  csrPkg::wordT  csrSrc,
  input  csrPkg::wordT  readVal,
  output csrPkg::wordT  writeVal
);

  import csrPkg::*;

  ////////////////////
  // Write value
  ////////////////////

  // The value that a CSR instruction stores depends on its kind
  // Read-write replaces the register, read-set and read-clear
  // modify the bits of the current read value
  always_comb begin
    case (csrOp)
      // Plain replacement by the source operand
      csrRw: begin
        writeVal = csrSrc;
      end
      // Every one in the source sets the matching bit
      csrRs: begin
        writeVal = readVal | csrSrc;
      end
      // Every one in the source clears the matching bit
      csrRc: begin
        writeVal = readVal & ~csrSrc;
      end
      // The unused encoding behaves as read-write
      default: begin
        writeVal = csrSrc;
      end
    endcase
  end

  // The register blocks decide whether the value is actually stored
  // This block never looks at the address or at the valid level

endmodule

`default_nettype wire

//--- verification/csrUserTb.sv
`default_nettype none

module csrUserTb;

  timeunit 1ns;
  timeprecision 100ps;

  import csrPkg::*;

  localparam int clkPeriod = 20;
  localparam int resetCycles = 16;
  // Directed phases take a little under 200 cycles, the random mix 2000
  localparam int directedCycles = 200;
  localparam int randomCycles = 2000;
  localparam int marginCycles = 100;
  localparam wordT resetVector = 32'h8000_0101;

  logic clk = 1'b0;
  logic rst;
  logic instrValid;
  logic csrWrite;
  csrOpT csrOp;
  csrAddrT csrAddr;
  wordT csrSrc;
  logic uTrap;
  logic uRet;
  wordT nextEpc;
  wordT nextCause;
  wordT nextTval;
  logic irqTimer;
  logic irqExt;
  wordT csrReadVal;
  logic illegalCsr;
  wordT uepcOut;
  wordT utvecOut;
  logic uIrqPending;

  // Reference model of the eight user CSRs
  logic mUieBit;
  logic mUpieBit;
  logic mUsip;
  intBitsT mUie;
  wordT mUtvec;
  wordT mUscratch;
  wordT mUepc;
  wordT mUcause;
  wordT mUtval;

  logic [63:0] lcgState;

  csrUserUnit #(
    .resetVector (resetVector)
  ) dut_i (
    .clk         (clk),
    .rst         (rst),
    .instrValid  (instrValid),
    .csrWrite    (csrWrite),
    .csrOp       (csrOp),
    .csrAddr     (csrAddr),
    .csrSrc      (csrSrc),
    .uTrap       (uTrap),
    .uRet        (uRet),
    .nextEpc     (nextEpc),
    .nextCause   (nextCause),
    .nextTval    (nextTval),
    .irqTimer    (irqTimer),
    .irqExt      (irqExt),
    .csrReadVal  (csrReadVal),
    .illegalCsr  (illegalCsr),
    .uepcOut     (uepcOut),
    .utvecOut    (utvecOut),
    .uIrqPending (uIrqPending)
  );

  always #(clkPeriod / 2) clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  // 64-bit LCG, the upper half has the better random bits
  function automatic wordT nextRand();
    lcgState = lcgState * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcgState[63:32];
  endfunction

  function automatic csrOpT pickOp(input int idx);
    case (idx % 3)
      0: return csrRw;
      1: return csrRs;
      default: return csrRc;
    endcase
  endfunction

  function automatic csrAddrT mapAddr(input int idx);
    case (idx)
      0: return USTATUS_ADR;
      1: return UIE_ADR;
      2: return UTVEC_ADR;
      3: return USCRATCH_ADR;
      4: return UEPC_ADR;
      5: return UCAUSE_ADR;
      6: return UTVAL_ADR;
      default: return UIP_ADR;
    endcase
  endfunction

  function automatic logic isMapped(input csrAddrT addr);
    for (int j = 0; j < 8; j++) begin
      if (mapAddr(j) == addr) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Software bit from the model, timer and external bits straight from the levels
  function automatic intBitsT modelUip();
    intBitsT pend;
    pend = '0;
    pend[USI_BIT] = mUsip;
    pend[UTI_BIT] = irqTimer;
    pend[UEI_BIT] = irqExt;
    return pend;
  endfunction

  // Expected read value and legality of one address
  function automatic wordT expectedRead(input csrAddrT addr, output logic illegal);
    wordT value;
    value = '0;
    illegal = 1'b0;
    case (addr)
      USTATUS_ADR: begin
        value[UIE_BIT] = mUieBit;
        value[UPIE_BIT] = mUpieBit;
      end
      UIE_ADR:      value = wordT'(mUie);
      UTVEC_ADR:    value = mUtvec;
      USCRATCH_ADR: value = mUscratch;
      UEPC_ADR:     value = mUepc;
      UCAUSE_ADR:   value = mUcause;
      UTVAL_ADR:    value = mUtval;
      UIP_ADR:      value = wordT'(modelUip());
      default:      illegal = 1'b1;
    endcase
    return value;
  endfunction

  ////////////////////
  // Checking
  ////////////////////

  task automatic abortRun();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped after the first error");
  endtask

  task automatic checkWord(input string name, input wordT expected, input wordT actual);
    if (actual !== expected) begin
      $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
      abortRun();
    end
  endtask

  task automatic checkBit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
      abortRun();
    end
  endtask

  task automatic compareOutputs();
    wordT expRead;
    logic expIllegal;
    intBitsT enabledPend;
    expRead = expectedRead(csrAddr, expIllegal);
    enabledPend = mUie & modelUip();
    checkWord("csrReadVal", expRead, csrReadVal);
    checkBit("illegalCsr", expIllegal, illegalCsr);
    checkWord("uepcOut", mUepc, uepcOut);
    checkWord("utvecOut", mUtvec, utvecOut);
    checkBit("uIrqPending", mUieBit & (|enabledPend), uIrqPending);
  endtask

  // Applies the inputs seen at the coming edge to the model
  task automatic updateModel();
    wordT rdVal;
    wordT wv;
    logic illegal;
    logic wrOk;
    if (rst) begin
      mUieBit = 1'b0;
      mUpieBit = 1'b0;
      mUsip = 1'b0;
      mUie = '0;
      mUtvec = resetVector;
      mUscratch = '0;
      mUepc = '0;
      mUcause = '0;
      mUtval = '0;
    end else begin
      rdVal = expectedRead(csrAddr, illegal);
      case (csrOp)
        csrRs:   wv = rdVal | csrSrc;
        csrRc:   wv = rdVal & ~csrSrc;
        default: wv = csrSrc;
      endcase
      wrOk = instrValid && csrWrite && !illegal;
      // Trap and return override a ustatus write
      if (uTrap) begin
        mUpieBit = mUieBit;
        mUieBit = 1'b0;
      end else if (uRet) begin
        mUieBit = mUpieBit;
        mUpieBit = 1'b1;
      end else if (wrOk && csrAddr == USTATUS_ADR) begin
        mUieBit = wv[UIE_BIT];
        mUpieBit = wv[UPIE_BIT];
      end
      if (wrOk && csrAddr == UIE_ADR) begin
        mUie = '0;
        mUie[USI_BIT] = wv[USI_BIT];
        mUie[UTI_BIT] = wv[UTI_BIT];
        mUie[UEI_BIT] = wv[UEI_BIT];
      end
      if (wrOk && csrAddr == UIP_ADR) mUsip = wv[USI_BIT];
      if (wrOk && csrAddr == UTVEC_ADR) mUtvec = wv & ~wordT'(2);
      if (wrOk && csrAddr == USCRATCH_ADR) mUscratch = wv;
      // Trap capture beats a CSR write to the same registers
      if (uTrap) begin
        mUepc = nextEpc & ~wordT'(1);
        mUcause = nextCause;
        mUtval = nextTval;
      end else if (wrOk) begin
        if (csrAddr == UEPC_ADR) mUepc = wv & ~wordT'(1);
        if (csrAddr == UCAUSE_ADR) mUcause = wv;
        if (csrAddr == UTVAL_ADR) mUtval = wv;
      end
    end
  endtask

  // Outputs are compared 2 ns before each edge, then the model steps
  always begin
    @(posedge clk);
    #(clkPeriod - 2);
    if (!rst) begin
      compareOutputs();
    end
    updateModel();
  end

  initial begin
    #((resetCycles + directedCycles + randomCycles + marginCycles) * clkPeriod);
    $display("Timeout: the tests did not finish in the expected number of cycles");
    abortRun();
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Waits for the next drive point and returns the strobes to idle
  task automatic nextCycle();
    @(posedge clk);
    #2;
    instrValid = 1'b0;
    csrWrite = 1'b0;
    uTrap = 1'b0;
    uRet = 1'b0;
  endtask

  task automatic csrInstr(input csrOpT op, input csrAddrT addr, input wordT src);
    instrValid = 1'b1;
    csrWrite = 1'b1;
    csrOp = op;
    csrAddr = addr;
    csrSrc = src;
    nextCycle();
  endtask

  task automatic csrRead(input csrAddrT addr);
    instrValid = 1'b1;
    csrAddr = addr;
    nextCycle();
  endtask

  initial begin : stimulus
    wordT r;
    csrAddrT addr;
    lcgState = 64'd46246;
    rst = 1'b1;
    instrValid = 1'b0;
    csrWrite = 1'b0;
    csrOp = csrRw;
    csrAddr = '0;
    csrSrc = '0;
    uTrap = 1'b0;
    uRet = 1'b0;
    nextEpc = '0;
    nextCause = '0;
    nextTval = '0;
    irqTimer = 1'b0;
    irqExt = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #2;
    rst = 1'b0;

    // Reset values of the whole map
    for (int i = 0; i < 8; i++) csrRead(mapAddr(i));

    // Each kind on each register, read back one cycle later
    // Read-set with all ones exposes the bits that must stay zero
    for (int i = 0; i < 8; i++) begin
      for (int k = 0; k < 3; k++) begin
        csrInstr(pickOp(k), mapAddr(i), (k == 1) ? '1 : nextRand());
        csrRead(mapAddr(i));
      end
    end

    // Unmapped addresses must read zero and change nothing
    repeat (40) begin
      do begin
        r = nextRand();
        addr = r[11:0];
      end while (isMapped(addr));
      csrInstr(pickOp(int'(r[17:16])), addr, nextRand());
    end
    for (int i = 0; i < 8; i++) csrRead(mapAddr(i));

    // Trap entry with a CSR write to the same register in that cycle
    csrInstr(csrRw, USTATUS_ADR, wordT'(1) << UIE_BIT);
    for (int i = 4; i < 7; i++) begin
      nextEpc = nextRand() | wordT'(1);
      nextCause = nextRand();
      nextTval = nextRand();
      uTrap = 1'b1;
      csrInstr(csrRw, mapAddr(i), nextRand());
    end
    // Enable again so that the next trap has a set bit to save
    csrInstr(csrRw, USTATUS_ADR, wordT'(1) << UIE_BIT);
    uTrap = 1'b1;
    csrInstr(csrRs, USTATUS_ADR, '1);
    csrRead(USTATUS_ADR);
    csrRead(UCAUSE_ADR);
    csrRead(UTVAL_ADR);

    // Return, then every mix of enables and interrupt levels
    // The enable saved by the last trap comes back here
    uRet = 1'b1;
    nextCycle();
    csrRead(USTATUS_ADR);
    for (int k = 0; k < 16; k++) begin
      irqTimer = k[0];
      irqExt = k[1];
      csrInstr(csrRw, UIE_ADR, nextRand());
      csrInstr(csrRw, UIP_ADR, wordT'(k[2]));
      csrInstr(csrRw, USTATUS_ADR, wordT'(k[3]));
      csrRead(UIP_ADR);
    end

    // Random mix, about a quarter of the cycles have instrValid low
    repeat (randomCycles) begin
      r = nextRand();
      addr = r[31:20];
      instrValid = (r[3:0] >= 4'd4);
      csrWrite = r[4];
      csrOp = pickOp(int'(r[7:5]));
      csrAddr = (r[19:16] == 4'd0) ? addr : mapAddr(int'(r[22:20]));
      csrSrc = nextRand();
      uTrap = (r[11:8] == 4'd0);
      uRet = (r[11:8] == 4'd1);
      if (r[14:12] == 3'd0) irqTimer = ~irqTimer;
      if (r[15] && r[6:5] == 2'd0) irqExt = ~irqExt;
      nextEpc = nextRand();
      nextCause = nextRand();
      nextTval = nextRand();
      nextCycle();
    end

    // One more cycle so that the last inputs are compared as well
    nextCycle();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire
